/* filelist.f */
mem_pkg.sv
word_ram.sv
mem_ctrl.sv
load_store_unit.sv
mem_subsys_top.sv
tb_mem_subsys.sv

/* load_store_unit.sv */
`timescale 1ns/100ps

module load_store_unit
    import mem_pkg::*;
(
    input  ls_req_t  ls_req,
    output mem_req_t mem_req,
    input  word_t    rdata,
    output word_t    load_data,
    output logic     misaligned
);

    logic      is_load;
    logic      is_store;
    logic      is_signed;
    logic      size_half;
    logic      size_word;
    byte_off_t offset;
    logic      access_ok;

    assign offset = ls_req.addr[1:0];

    always_comb begin
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_signed = 1'b0;
        size_half = 1'b0;
        size_word = 1'b0;
        case (ls_req.op)
            LS_LB: begin
                is_load   = 1'b1;
                is_signed = 1'b1;
            end
            LS_LH: begin
                is_load   = 1'b1;
                is_signed = 1'b1;
                size_half = 1'b1;
            end
            LS_LW: begin
                is_load   = 1'b1;
                size_word = 1'b1;
            end
            LS_LBU: begin
                is_load = 1'b1;
            end
            LS_LHU: begin
                is_load   = 1'b1;
                size_half = 1'b1;
            end
            LS_SB: begin
                is_store = 1'b1;
            end
            LS_SH: begin
                is_store  = 1'b1;
                size_half = 1'b1;
            end
            LS_SW: begin
                is_store  = 1'b1;
                size_word = 1'b1;
            end
            default: begin
                is_load = 1'b0; // LS_NONE and unused codes do nothing.
            end
        endcase
    end

    // halfwords need bit 0 clear, words need both offset bits clear.
    assign misaligned = (is_load || is_store) &&
                        ((size_half && offset[0]) || (size_word && (offset != 2'd0)));

    // an access is usable when no offset bit falls inside its own size.
    assign access_ok  = (offset & {size_word, size_word | size_half}) == 2'b00;

    always_comb begin
        mem_req.addr  = ls_req.addr;
        mem_req.wdata = ls_req.wdata;
        mem_req.r_en  = is_load && access_ok;
        mem_req.w_en  = is_store && access_ok;
        if (!is_store) begin
            mem_req.mask = 4'b0000;
        end else if (size_word) begin
            mem_req.mask = 4'b1111;
        end else if (size_half) begin
            mem_req.mask = 4'b0011;
        end else begin
            mem_req.mask = 4'b0001;
        end
    end

    // the controller has already moved the addressed bytes down to lane zero.
    always_comb begin
        load_data = '0;
        if (mem_req.r_en) begin
            if (size_word) begin
                load_data = rdata;
            end else if (size_half) begin
                load_data = {{16{is_signed & rdata[15]}}, rdata[15:0]};
            end else begin
                load_data = {{24{is_signed & rdata[7]}}, rdata[7:0]};
            end
        end
    end

    // a misaligned store must never reach the RAM write port.
    a_no_misaligned_write: assert property (
        @(ls_req) !(misaligned && mem_req.w_en)
    ) else $error("load_store_unit: misaligned store was enabled");

endmodule

/* mem_ctrl.sv */
`timescale 1ns/100ps

module mem_ctrl
    import mem_pkg::*;
#(
    parameter int DEPTH_LOG2 = 7
) (
    input  mem_req_t              req,
    output word_t                 rdata,
    input  addr_t                 fetch_addr,
    input  logic                  fetch_en,
    output word_t                 fetch_data,
    output ram_wr_t               wr,
    output logic [DEPTH_LOG2-1:0] fetch_word_addr,
    output logic [DEPTH_LOG2-1:0] data_word_addr,
    input  word_t                 fetch_word,
    input  word_t                 data_word
);

    byte_off_t  offset;
    word_t      wdata_lane;
    byte_mask_t mask_lane;
    word_t      rdata_lane;

    assign offset = req.addr[1:0];

    // store data and mask move up by the byte offset, read data moves down.
    always_comb begin
        case (offset)
            2'd1: begin
                wdata_lane = {req.wdata[23:0], 8'h00};
                mask_lane  = {req.mask[2:0], 1'b0};
                rdata_lane = {8'h00, data_word[31:8]};
            end
            2'd2: begin
                wdata_lane = {req.wdata[15:0], 16'h0000};
                mask_lane  = {req.mask[1:0], 2'b00};
                rdata_lane = {16'h0000, data_word[31:16]};
            end
            2'd3: begin
                wdata_lane = {req.wdata[7:0], 24'h000000};
                mask_lane  = {req.mask[0], 3'b000};
                rdata_lane = {24'h000000, data_word[31:24]};
            end
            default: begin
                wdata_lane = req.wdata;
                mask_lane  = req.mask;
                rdata_lane = data_word;
            end
        endcase
    end

    always_comb begin
        wr.word_addr = req.addr[XLEN-1:2];
        wr.wdata     = wdata_lane;
        wr.mask      = mask_lane;
        wr.en        = req.w_en;
    end

    // the RAM only sees the low word address bits. Larger addresses wrap.
    assign data_word_addr  = req.addr[DEPTH_LOG2+1:2];
    assign fetch_word_addr = fetch_addr[DEPTH_LOG2+1:2];

    assign rdata      = req.r_en ? rdata_lane : '0;
    assign fetch_data = fetch_en ? fetch_word : '0; // fetch ignores address bits 1:0.

    // the load/store unit only issues aligned writes, so every lane survives the shift.
    a_no_lane_lost: assert property (
        @(req) req.w_en |-> ($countones(mask_lane) == $countones(req.mask))
    ) else $error("mem_ctrl: store mask shifted past the top byte lane");

endmodule

/* mem_pkg.sv */
package mem_pkg;

    localparam int XLEN = 32;
    localparam int WORD_BYTES = XLEN / 8;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [WORD_BYTES-1:0] byte_mask_t; // bit 0 enables the lowest byte.
    typedef logic [1:0] byte_off_t;
    typedef logic [XLEN-3:0] word_addr_t; // byte address without its two offset bits.

    // memory operations as the core issues them.
    typedef enum logic [3:0] {
        LS_NONE = 4'd0,
        LS_LB   = 4'd1,
        LS_LH   = 4'd2,
        LS_LW   = 4'd3,
        LS_LBU  = 4'd4,
        LS_LHU  = 4'd5,
        LS_SB   = 4'd6,
        LS_SH   = 4'd7,
        LS_SW   = 4'd8
    } ls_op_t;

    typedef struct packed {
        ls_op_t op;
        addr_t  addr;
        word_t  wdata;
    } ls_req_t;

    // data and mask are still at lane zero here.
    typedef struct packed {
        addr_t      addr;
        word_t      wdata;
        byte_mask_t mask;
        logic       r_en;
        logic       w_en;
    } mem_req_t;

    // data and mask already sit in their byte lanes.
    typedef struct packed {
        word_addr_t word_addr;
        word_t      wdata;
        byte_mask_t mask;
        logic       en;
    } ram_wr_t;

endpackage

/* mem_subsys_top.sv */
`timescale 1ns/100ps

module mem_subsys_top
    import mem_pkg::*;
#(
    parameter int DEPTH_LOG2 = 7
) (
    input  logic    clk,
    input  logic    rst_n,
    input  ls_req_t ls_req,
    output word_t   load_data,
    output logic    misaligned,
    input  addr_t   fetch_addr,
    input  logic    fetch_en,
    output word_t   fetch_data
);

    mem_req_t              mem_req;
    word_t                 rdata;
    ram_wr_t               wr;
    logic [DEPTH_LOG2-1:0] fetch_word_addr;
    logic [DEPTH_LOG2-1:0] data_word_addr;
    word_t                 fetch_word;
    word_t                 data_word;

    load_store_unit u_lsu (
        .ls_req    (ls_req),
        .mem_req   (mem_req),
        .rdata     (rdata),
        .load_data (load_data),
        .misaligned(misaligned)
    );

    mem_ctrl #(
        .DEPTH_LOG2(DEPTH_LOG2)
    ) u_mem_ctrl (
        .req            (mem_req),
        .rdata          (rdata),
        .fetch_addr     (fetch_addr),
        .fetch_en       (fetch_en),
        .fetch_data     (fetch_data),
        .wr             (wr),
        .fetch_word_addr(fetch_word_addr),
        .data_word_addr (data_word_addr),
        .fetch_word     (fetch_word),
        .data_word      (data_word)
    );

    word_ram #(
        .DEPTH_LOG2(DEPTH_LOG2)
    ) u_word_ram (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr             (wr),
        .fetch_word_addr(fetch_word_addr),
        .fetch_word     (fetch_word),
        .data_word_addr (data_word_addr),
        .data_word      (data_word)
    );

endmodule

/* tb_mem_subsys.sv */
`timescale 1ns/100ps

module tb_mem_subsys
    import mem_pkg::*;
;

    localparam int DEPTH_LOG2 = 7;
    localparam int RAM_BYTES = 4 << DEPTH_LOG2;
    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;

    // cycles spent in each test phase, used for the watchdog limit.
    localparam int RESET_READS = 20;
    localparam int WORD_CYCLES = 16 * 2;
    localparam int SUB_STORE_CYCLES = 8 * 12;
    localparam int EXT_CYCLES = 8 * 13;
    localparam int MISALIGN_CYCLES = 8 * 10;
    localparam int MIX_OPS = 2000;
    localparam int TAIL_CYCLES = 4;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 1 + RESET_READS + WORD_CYCLES +
                                  SUB_STORE_CYCLES + EXT_CYCLES + MISALIGN_CYCLES +
                                  MIX_OPS + TAIL_CYCLES;
    localparam int WATCHDOG_NS = TOTAL_CYCLES * CLK_PERIOD + 400;

    logic    clk;
    logic    rst_n;
    ls_req_t ls_req;
    word_t   load_data;
    logic    misaligned;
    addr_t   fetch_addr;
    logic    fetch_en;
    word_t   fetch_data;

    logic [7:0] shadow [RAM_BYTES]; // byte image of what the RAM should hold.

    word_t exp_load;
    word_t exp_fetch;
    logic  exp_mis;
    string test_name;

    integer      seed = 12864;
    int unsigned pick;
    addr_t       ad;
    word_t       wd;

    mem_subsys_top #(
        .DEPTH_LOG2(DEPTH_LOG2)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .ls_req    (ls_req),
        .load_data (load_data),
        .misaligned(misaligned),
        .fetch_addr(fetch_addr),
        .fetch_en  (fetch_en),
        .fetch_data(fetch_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    // a random word-aligned address inside the RAM.
    function automatic addr_t rand_word_addr();
        return addr_t'($random(seed)) & addr_t'(RAM_BYTES - 4);
    endfunction

    function automatic word_t read_word(input logic [DEPTH_LOG2+1:0] b);
        logic [DEPTH_LOG2+1:0] idx;
        idx = {b[DEPTH_LOG2+1:2], 2'b00};
        return {shadow[idx + 2'd3], shadow[idx + 2'd2], shadow[idx + 1'b1], shadow[idx]};
    endfunction

    // drives one request on the falling edge and works out what the outputs must show.
    task automatic drive_op(input ls_op_t op, input addr_t a, input word_t d,
                            input logic fen, input addr_t fa);
        logic                  is_ld;
        logic                  is_st;
        logic                  bad;
        logic [DEPTH_LOG2+1:0] base;
        @(negedge clk);
        is_ld = op inside {LS_LB, LS_LH, LS_LW, LS_LBU, LS_LHU};
        is_st = op inside {LS_SB, LS_SH, LS_SW};
        bad   = (op inside {LS_LH, LS_LHU, LS_SH} && a[0]) ||
                (op inside {LS_LW, LS_SW} && (a[1:0] != 2'b00));
        base  = a[DEPTH_LOG2+1:0]; // higher address bits wrap.
        exp_mis  = bad;
        exp_load = '0;
        if (is_ld && !bad) begin
            case (op)
                LS_LB:   exp_load = {{24{shadow[base][7]}}, shadow[base]};
                LS_LBU:  exp_load = {24'h000000, shadow[base]};
                LS_LH:   exp_load = {{16{shadow[base + 1'b1][7]}}, shadow[base + 1'b1],
                                     shadow[base]};
                LS_LHU:  exp_load = {16'h0000, shadow[base + 1'b1], shadow[base]};
                default: exp_load = read_word(base);
            endcase
        end
        exp_fetch = fen ? read_word(fa[DEPTH_LOG2+1:0]) : '0;
        // the RAM takes the store at the next rising edge, after this cycle's checks.
        if (is_st && !bad) begin
            shadow[base] = d[7:0];
            if (op != LS_SB) begin
                shadow[base + 1'b1] = d[15:8];
            end
            if (op == LS_SW) begin
                shadow[base + 2'd2] = d[23:16];
                shadow[base + 2'd3] = d[31:24];
            end
        end
        ls_req.op    = op;
        ls_req.addr  = a;
        ls_req.wdata = d;
        fetch_addr   = fa;
        fetch_en     = fen;
    endtask

    task automatic idle_cycle();
        drive_op(LS_NONE, '0, '0, 1'b0, '0);
    endtask

    a_load_data: assert property (
        @(posedge clk) disable iff (!rst_n) load_data == exp_load
    ) else fail_now($sformatf("ERROR %s: load_data expected %h actual %h",
                              test_name, exp_load, $sampled(load_data)));

    a_misaligned: assert property (
        @(posedge clk) disable iff (!rst_n) misaligned == exp_mis
    ) else fail_now($sformatf("ERROR %s: misaligned expected %b actual %b",
                              test_name, exp_mis, $sampled(misaligned)));

    a_fetch_data: assert property (
        @(posedge clk) disable iff (!rst_n) fetch_data == exp_fetch
    ) else fail_now($sformatf("ERROR %s: fetch_data expected %h actual %h",
                              test_name, exp_fetch, $sampled(fetch_data)));

    initial begin
        #(WATCHDOG_NS);
        fail_now("timeout: the test phases did not finish in the expected time");
    end

    initial begin
        rst_n        = 1'b0;
        ls_req.op    = LS_NONE;
        ls_req.addr  = '0;
        ls_req.wdata = '0;
        fetch_addr   = '0;
        fetch_en     = 1'b0;
        exp_load     = '0;
        exp_fetch    = '0;
        exp_mis      = 1'b0;
        test_name    = "reset";
        for (int i = 0; i < RAM_BYTES; i++) begin
            shadow[i] = 8'h00;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_name = "reset_contents";
        for (int i = 0; i < RESET_READS; i++) begin
            drive_op(LS_LW, rand_word_addr(), '0, 1'b1, addr_t'($random(seed)));
        end

        test_name = "word_store_load";
        for (int i = 0; i < WORD_CYCLES / 2; i++) begin
            ad = rand_word_addr();
            wd = word_t'($random(seed));
            drive_op(LS_SW, ad, wd, 1'b0, ad); // fetch disabled must read zero.
            drive_op(LS_LW, ad, '0, 1'b1, ad);
        end

        test_name = "sub_word_store";
        for (int w = 0; w < 8; w++) begin
            ad = rand_word_addr();
            for (int k = 0; k < 4; k++) begin
                drive_op(LS_SB, ad + k, word_t'($random(seed)), 1'b1, ad);
                drive_op(LS_LW, ad, '0, 1'b1, ad);
            end
            for (int k = 0; k < 4; k += 2) begin
                drive_op(LS_SH, ad + k, word_t'($random(seed)), 1'b1, ad);
                drive_op(LS_LW, ad, '0, 1'b1, ad);
            end
        end

        test_name = "load_extend";
        for (int w = 0; w < 8; w++) begin
            ad = rand_word_addr();
            wd = word_t'($random(seed));
            // odd rounds set every byte's sign bit, even rounds clear it.
            wd = w[0] ? (wd | 32'h80808080) : (wd & 32'h7f7f7f7f);
            drive_op(LS_SW, ad, wd, 1'b0, '0);
            for (int k = 0; k < 4; k++) begin
                drive_op(LS_LB, ad + k, '0, 1'b0, '0);
                drive_op(LS_LBU, ad + k, '0, 1'b0, '0);
            end
            for (int k = 0; k < 4; k += 2) begin
                drive_op(LS_LH, ad + k, '0, 1'b0, '0);
                drive_op(LS_LHU, ad + k, '0, 1'b0, '0);
            end
        end

        test_name = "misaligned";
        for (int w = 0; w < 8; w++) begin
            ad = rand_word_addr();
            drive_op(LS_SW, ad, word_t'($random(seed)), 1'b0, '0);
            drive_op(LS_SH, ad + 1, 32'hdeadbeef, 1'b1, ad);
            drive_op(LS_SH, ad + 3, 32'hdeadbeef, 1'b1, ad);
            drive_op(LS_SW, ad + 1, 32'hcafef00d, 1'b1, ad);
            drive_op(LS_SW, ad + 2, 32'hcafef00d, 1'b1, ad);
            drive_op(LS_SW, ad + 3, 32'hcafef00d, 1'b1, ad);
            drive_op(LS_LH, ad + 1, '0, 1'b0, '0);
            drive_op(LS_LHU, ad + 3, '0, 1'b0, '0);
            drive_op(LS_LW, ad + 2, '0, 1'b0, '0);
            drive_op(LS_LW, ad, '0, 1'b1, ad); // the word must be unchanged.
        end

        test_name = "random_mix";
        for (int i = 0; i < MIX_OPS; i++) begin
            pick = $unsigned($random(seed)) % 9;
            if ($random(seed) & 1) begin
                ad = addr_t'($random(seed)); // mostly beyond the RAM, so it wraps.
            end else begin
                ad = addr_t'($random(seed)) & addr_t'(RAM_BYTES - 1);
            end
            wd = word_t'($random(seed));
            drive_op(ls_op_t'(pick[3:0]), ad, wd, 1'(($random(seed) & 3) != 0),
                     addr_t'($random(seed)));
        end

        test_name = "final_idle";
        idle_cycle();
        @(posedge clk);
        @(negedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* word_ram.sv */
`timescale 1ns/100ps

module word_ram
    import mem_pkg::*;
#(
    parameter int DEPTH_LOG2 = 7
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ram_wr_t               wr,
    input  logic [DEPTH_LOG2-1:0] fetch_word_addr,
    output word_t                 fetch_word,
    input  logic [DEPTH_LOG2-1:0] data_word_addr,
    output word_t                 data_word
);

    localparam int DEPTH = 2 ** DEPTH_LOG2;

    word_t                 mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_addr;

    // the word address must fit in what remains of a byte address.
    if (DEPTH_LOG2 < 1 || DEPTH_LOG2 > XLEN - 2) begin : g_depth_check
        $error("word_ram: DEPTH_LOG2 out of range");
    end

    // higher word address bits are dropped, so accesses wrap around the array.
    assign wr_addr = wr.word_addr[DEPTH_LOG2-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr.en) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (wr.mask[b]) begin
                    mem[wr_addr][8*b +: 8] <= wr.wdata[8*b +: 8];
                end
            end
        end
    end

    // both read ports are asynchronous, so a load in the store cycle sees the old word.
    assign fetch_word = mem[fetch_word_addr];
    assign data_word  = mem[data_word_addr];

    // an enabled write with no lanes points at a broken mask path upstream.
    a_write_has_lanes: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr.en |-> (wr.mask != '0)
    ) else $error("word_ram: write enabled with an empty byte mask");

endmodule
